/* tb.f */
+incdir+hdl
hdl/mult_pkg.sv
hdl/csa_array_stage.sv
hdl/carry_propagate_adder.sv
hdl/credit_out_queue.sv
hdl/mult_top.sv
dv/mult_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f \
	--top-module mult_tb \
	-Mdir obj_dir \
	-o mult_tb_sim

sim_output=$(./obj_dir/mult_tb_sim)
printf '%s\n' "$sim_output"

if printf '%s\n' "$sim_output" | grep -qx "TEST RESULT: PASS"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

/* dv/mult_tb.sv */
`default_nettype none

`include "mult_defs.svh"

module mult_tb;

	import mult_pkg::*;

	localparam int DEPTH      = `MULT_QUEUE_DEPTH;
	localparam int TABLE_LEN  = 18;
	localparam int RANDOM_LEN = 200;
	localparam int BP_LEN     = 16;
	localparam int WATCHDOG_CYCLES = 20 * (TABLE_LEN + RANDOM_LEN + BP_LEN) + 200;

	// downstream credit return policies.
	localparam int POLICY_IMMEDIATE = 0;
	localparam int POLICY_WITHHOLD  = 1;
	localparam int POLICY_TRICKLE   = 2;

	typedef struct packed {
		logic [`MULT_WIDTH-1:0]      x;
		logic [`MULT_WIDTH-1:0]      y;
		logic [`MULT_PROD_WIDTH-1:0] product;
	} vector_t;

	// operand pairs with their 32-bit unsigned products.
	vector_t vectors [TABLE_LEN] = '{
		'{16'h0000, 16'h0000, 32'h0000_0000},
		'{16'h0000, 16'hFFFF, 32'h0000_0000},
		'{16'h1234, 16'h0000, 32'h0000_0000},
		'{16'h0001, 16'hBEEF, 32'h0000_BEEF},
		'{16'hBEEF, 16'h0001, 32'h0000_BEEF},
		'{16'h0001, 16'h0001, 32'h0000_0001},
		'{16'hFFFF, 16'h0001, 32'h0000_FFFF},
		'{16'hFFFF, 16'hFFFF, 32'hFFFE_0001},
		'{16'h8000, 16'h8000, 32'h4000_0000},
		'{16'h0100, 16'h0010, 32'h0000_1000},
		'{16'h0002, 16'h4000, 32'h0000_8000},
		'{16'h8000, 16'h0002, 32'h0001_0000},
		'{16'h8000, 16'hFFFF, 32'h7FFF_8000},
		'{16'hAAAA, 16'h5555, 32'h38E3_1C72},
		'{16'h5555, 16'h5555, 32'h1C71_8E39},
		'{16'hAAAA, 16'hAAAA, 32'h71C6_38E4},
		'{16'hFFFF, 16'hAAAA, 32'hAAA9_5556},
		'{16'h00FF, 16'hFF00, 32'h00FE_0100}
	};

	logic           clk = 1'b0;
	logic           rst_n;
	logic           in_valid;
	mult_operands_t in_ops;
	logic           in_credit;
	logic           out_valid;
	mult_product_t  out_product;
	logic           out_credit = 1'b0;

	int beats_sent       = 0; // written by the stimulus only.
	int credits_back     = 0; // in_credit pulses, written by the monitor only.
	int results_seen     = 0;
	int credits_returned = 0; // out_credit pulses, written by the downstream model only.
	int mon_errs         = 0;
	int main_errs        = 0;
	int policy           = POLICY_IMMEDIATE;
	int tick             = 0;
	int seed             = 81;
	int base_sent;
	int base_back;
	int base_seen;
	int base_errs;
	string         test_name = "reset";
	mult_product_t want;
	mult_product_t scoreboard [$];

	mult_top DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_ops      (in_ops),
		.in_credit   (in_credit),
		.out_valid   (out_valid),
		.out_product (out_product),
		.out_credit  (out_credit)
	);

	always #5 clk = ~clk;

	function automatic int upstream_credits();
		return DEPTH - beats_sent + credits_back;
	endfunction

	function automatic int downstream_credits();
		return DEPTH - results_seen + credits_returned;
	endfunction

	function automatic int owed_credits();
		return results_seen - credits_returned;
	endfunction

	// Outputs are registered on the rising edge, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (rst_n) begin
			if (in_credit) credits_back++;
			if (out_valid) begin
				assert (downstream_credits() > 0) else begin
					$display("%s: out_valid rose while downstream held no credit", test_name);
					mon_errs++;
				end
				results_seen++;
				assert (scoreboard.size() != 0) else begin
					$display("%s: out_valid rose with no result outstanding", test_name);
					mon_errs++;
				end
				if (scoreboard.size() != 0) begin
					want = scoreboard.pop_front();
					assert (out_product === want) else begin
						$display("ERR %s expected %h actual %h", test_name, want, out_product);
						mon_errs++;
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		#1;
		out_credit = 1'b0;
		tick++;
		if (rst_n && owed_credits() > 0) begin
			if (policy == POLICY_IMMEDIATE || (policy == POLICY_TRICKLE && tick % 4 == 0)) begin
				out_credit = 1'b1;
				credits_returned++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: %s did not finish within %0d cycles", test_name, WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic start_test(input string name);
		test_name = name;
		base_sent = beats_sent;
		base_back = credits_back;
		base_seen = results_seen;
		base_errs = mon_errs + main_errs;
	endtask

	// Called 1 time unit after a rising edge and returns at the same point.
	task automatic send_beat(input logic [`MULT_WIDTH-1:0] a, input logic [`MULT_WIDTH-1:0] b,
	                         input mult_product_t expected);
		while (upstream_credits() == 0) begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_ops   = '{x: a, y: b};
		scoreboard.push_back(expected);
		beats_sent++;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic finish_test();
		int errs;
		while (scoreboard.size() != 0 || owed_credits() != 0) @(negedge clk);
		repeat (3) @(negedge clk);
		assert (upstream_credits() == DEPTH) else begin
			$display("ERR %s upstream credits expected %0d actual %0d",
			         test_name, DEPTH, upstream_credits());
			main_errs++;
		end
		assert ((credits_back - base_back) == (results_seen - base_seen)) else begin
			$display("ERR %s in_credit pulses expected %0d actual %0d",
			         test_name, results_seen - base_seen, credits_back - base_back);
			main_errs++;
		end
		assert ((results_seen - base_seen) == (beats_sent - base_sent)) else begin
			$display("ERR %s results expected %0d actual %0d",
			         test_name, beats_sent - base_sent, results_seen - base_seen);
			main_errs++;
		end
		errs = mon_errs + main_errs - base_errs;
		if (errs == 0) $display("%s: ok, %0d results", test_name, results_seen - base_seen);
		else $display("%s: failed with %0d errors", test_name, errs);
		@(posedge clk);
		#1;
	endtask

	initial begin
		logic [31:0]            r;
		logic [`MULT_WIDTH-1:0] a;
		logic [`MULT_WIDTH-1:0] b;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_ops   = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		start_test("reset_idle");
		repeat (8) begin
			@(negedge clk);
			assert (out_valid == 1'b0 && in_credit == 1'b0) else begin
				$display("ERR %s out_valid,in_credit expected 00 actual %b%b",
				         test_name, out_valid, in_credit);
				main_errs++;
			end
		end
		@(posedge clk);
		#1;
		finish_test();

		start_test("table_products");
		for (int i = 0; i < TABLE_LEN; i++) begin
			send_beat(vectors[i].x, vectors[i].y, vectors[i].product);
		end
		finish_test();

		start_test("random_stream");
		for (int i = 0; i < RANDOM_LEN; i++) begin
			r = $random(seed);
			a = r[15:0];
			b = r[31:16];
			send_beat(a, b, {16'h0000, a} * {16'h0000, b});
		end
		finish_test();

		// the queue fills once downstream credits are gone, then drains slowly.
		start_test("back_pressure");
		policy = POLICY_WITHHOLD;
		fork
			begin
				for (int i = 0; i < BP_LEN; i++) begin
					r = $random(seed);
					a = r[15:0];
					b = r[31:16];
					send_beat(a, b, {16'h0000, a} * {16'h0000, b});
				end
			end
			begin
				while (upstream_credits() != 0 || downstream_credits() != 0) @(negedge clk);
				repeat (20) @(negedge clk);
				policy = POLICY_TRICKLE;
			end
		join
		finish_test();
		policy = POLICY_IMMEDIATE;

		$display("4 tests, %0d results checked, %0d errors", results_seen, mon_errs + main_errs);
		if (mon_errs + main_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/mult_top.sv */
`default_nettype none

`include "mult_defs.svh"

module mult_top (
	input  wire logic                     clk,
	input  wire logic                     rst_n,
	input  wire logic                     in_valid,
	input  wire mult_pkg::mult_operands_t in_ops,
	output logic                          in_credit,
	output logic                          out_valid,
	output mult_pkg::mult_product_t       out_product,
	input  wire logic                     out_credit
);

	mult_pkg::csa_state_t    stage_in;
	mult_pkg::csa_state_t    stage_mid;
	mult_pkg::csa_state_t    stage_last;
	logic                    push_valid;
	mult_pkg::mult_product_t push_product;

	// the first stage seeds its own sum and carry rows.
	assign stage_in = '{
		valid:     in_valid,
		operands:  in_ops,
		row_sum:   '0,
		row_carry: '0,
		low_bits:  '0
	};

	csa_array_stage #(
		.FIRST_ROW (0),
		.LAST_ROW  (`MULT_SPLIT_ROW - 1)
	) u_stage_lo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_state  (stage_in),
		.out_state (stage_mid)
	);

	csa_array_stage #(
		.FIRST_ROW (`MULT_SPLIT_ROW),
		.LAST_ROW  (`MULT_WIDTH - 1)
	) u_stage_hi (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_state  (stage_mid),
		.out_state (stage_last)
	);

	carry_propagate_adder u_cpa (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_state     (stage_last),
		.push_valid   (push_valid),
		.push_product (push_product)
	);

	// Upstream credits bound the items in flight, so the queue never overflows.
	credit_out_queue #(
		.DEPTH (`MULT_QUEUE_DEPTH)
	) u_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.push_valid   (push_valid),
		.push_product (push_product),
		.out_credit   (out_credit),
		.out_valid    (out_valid),
		.out_product  (out_product),
		.in_credit    (in_credit)
	);

endmodule

`default_nettype wire

/* hdl/credit_out_queue.sv */
`default_nettype none

`include "mult_defs.svh"

module credit_out_queue #(
	parameter int DEPTH = `MULT_QUEUE_DEPTH
) (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    push_valid,
	input  wire mult_pkg::mult_product_t push_product,
	input  wire logic                    out_credit,
	output logic                         out_valid,
	output mult_pkg::mult_product_t      out_product,
	output logic                         in_credit
);

	import mult_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mult_product_t mem [DEPTH];

	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic [`MULT_CREDIT_W-1:0] ds_credits; // credits held for the downstream consumer.
	logic                     pop;
	logic                     pop_q;
	mult_product_t            product_q;

	// A result leaves only when one is queued and downstream has room for it.
	assign pop = (count != '0) && (ds_credits != '0);

	always_ff @(posedge clk) begin
		if (push_valid) begin
			mem[wr_ptr] <= push_product;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({push_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ds_credits <= `MULT_CREDIT_W'(`MULT_QUEUE_DEPTH);
		end else begin
			case ({out_credit, pop})
				2'b10:   ds_credits <= ds_credits + 1'b1;
				2'b01:   ds_credits <= ds_credits - 1'b1;
				default: ds_credits <= ds_credits;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pop_q <= 1'b0;
		end else begin
			pop_q <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			product_q <= mem[rd_ptr];
		end
	end

	// A freed slot goes back upstream in the same cycle the result goes out.
	assign out_valid   = pop_q;
	assign in_credit   = pop_q;
	assign out_product = product_q;

endmodule

`default_nettype wire

/* hdl/carry_propagate_adder.sv */
`default_nettype none

`include "mult_defs.svh"

module carry_propagate_adder (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire mult_pkg::csa_state_t in_state,
	output logic                      push_valid,
	output mult_pkg::mult_product_t   push_product
);

	import mult_pkg::*;

	localparam int W = `MULT_WIDTH;

	logic [W-1:0]  upper;
	logic          ripple;
	mult_product_t product_q;

	// The carry row lines up with the sum row shifted down by one.
	always_comb begin
		ripple = 1'b0;
		for (int i = 0; i < W - 1; i++) begin
			upper[i] = in_state.row_carry[i] ^ in_state.row_sum[i+1] ^ ripple;
			ripple   = (in_state.row_carry[i] & in_state.row_sum[i+1]) |
			           (ripple & (in_state.row_carry[i] ^ in_state.row_sum[i+1]));
		end
		upper[W-1] = ripple; // the last carry out is the top product bit.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			push_valid <= 1'b0;
		end else begin
			push_valid <= in_state.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_state.valid) begin
			product_q <= {upper, in_state.low_bits};
		end
	end

	assign push_product = product_q;

endmodule

`default_nettype wire

/* hdl/csa_array_stage.sv */
`default_nettype none

`include "mult_defs.svh"

module csa_array_stage #(
	parameter int FIRST_ROW = 0,
	parameter int LAST_ROW  = `MULT_WIDTH - 1
) (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire mult_pkg::csa_state_t in_state,
	output mult_pkg::csa_state_t      out_state
);

	import mult_pkg::*;

	localparam int W = `MULT_WIDTH;

	logic [W-1:0] pp;       // partial product row being added.
	logic [W-1:0] sum_c;
	logic [W-2:0] carry_c;
	logic [W-1:0] nxt_sum;
	logic [W-1:0] low_c;

	logic           valid_q;
	mult_operands_t ops_q;
	logic [W-1:0]   sum_q;
	logic [W-2:0]   carry_q;
	logic [W-1:0]   low_q;

	// Each row shifts the running sum down by one bit and adds the new AND row with
	// full adders. The bit that falls out at position zero is a finished product bit.
	always_comb begin
		if (FIRST_ROW == 0) begin
			// row zero seeds the array, so start from an empty carry-save pair.
			sum_c   = '0;
			carry_c = '0;
			low_c   = '0;
		end else begin
			sum_c   = in_state.row_sum;
			carry_c = in_state.row_carry;
			low_c   = in_state.low_bits;
		end
		pp      = '0;
		nxt_sum = '0;
		for (int r = FIRST_ROW; r <= LAST_ROW; r++) begin
			pp = in_state.operands.x & {W{in_state.operands.y[r]}};
			nxt_sum[W-1] = pp[W-1]; // the top bit has nothing to add to yet.
			for (int i = 0; i < W - 1; i++) begin
				nxt_sum[i] = pp[i] ^ sum_c[i+1] ^ carry_c[i];
				carry_c[i] = (pp[i] & sum_c[i+1]) | (carry_c[i] & (pp[i] ^ sum_c[i+1]));
			end
			sum_c    = nxt_sum;
			low_c[r] = sum_c[0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_state.valid;
		end
	end

	// the payload only moves when a valid item passes through.
	always_ff @(posedge clk) begin
		if (in_state.valid) begin
			ops_q   <= in_state.operands;
			sum_q   <= sum_c;
			carry_q <= carry_c;
			low_q   <= low_c;
		end
	end

	assign out_state = '{
		valid:     valid_q,
		operands:  ops_q,
		row_sum:   sum_q,
		row_carry: carry_q,
		low_bits:  low_q
	};

endmodule

`default_nettype wire

/* hdl/mult_pkg.sv */
`default_nettype none

`include "mult_defs.svh"

package mult_pkg;

	typedef struct packed {
		logic [`MULT_WIDTH-1:0] x; // multiplicand.
		logic [`MULT_WIDTH-1:0] y; // multiplier, one array row per bit.
	} mult_operands_t;

	typedef logic [`MULT_PROD_WIDTH-1:0] mult_product_t;

	// carry-save snapshot handed from one pipeline stage to the next.
	typedef struct packed {
		logic                   valid;
		mult_operands_t         operands;
		logic [`MULT_WIDTH-1:0] row_sum;   // sum row after the last reduced row.
		logic [`MULT_WIDTH-2:0] row_carry; // carry row, one bit shorter than the sum row.
		logic [`MULT_WIDTH-1:0] low_bits;  // product bits already retired by the array.
	} csa_state_t;

endpackage

`default_nettype wire

/* hdl/mult_defs.svh */
`ifndef MULT_DEFS_SVH
`define MULT_DEFS_SVH

// operand width of the array multiplier.
`define MULT_WIDTH 16

// the full unsigned product is twice the operand width.
`define MULT_PROD_WIDTH (2 * `MULT_WIDTH)

// first multiplier row reduced by the second array stage.
`define MULT_SPLIT_ROW 8

// result slots in the output queue.
// Upstream starts with this many credits after reset.
`define MULT_QUEUE_DEPTH 4

// counter width that can hold a full set of credits.
`define MULT_CREDIT_W 3

`endif
